/* Makefile */
# Verilator build and run of the fabric testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
	  --top-module fabric_top_tb -Mdir obj_dir -f list.f

# run and decide pass or fail from the log
run: compile
	./obj_dir/Vfabric_top_tb +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* list.f */
source/fabric_pkg.sv
source/reset_req_sync.sv
source/reset_pulse_stretch.sv
source/reset_req_outputs.sv
source/count_accumulator.sv
source/fabric_top.sv
tb/fabric_top_props.sv
tb/fabric_top_tb.sv

/* source/count_accumulator.sv */
// step is sampled only on the prescaler wrap edge; the counter wraps silently at 2^32
`timescale 1ns/1ns

module count_accumulator import fabric_pkg::*; #(
  parameter int DIV_WIDTH = 24 // prescaler bits
) (
  input  logic   CLOCK_50,
  input  logic   arst_n,
  input  count_t count_control, // step from host
  output led_t   ledr
);

  logic [DIV_WIDTH-1:0] prescale; // free running divider
  count_t               counter;  // full accumulator
  logic                 tick;     // prescaler at zero

  assign tick = (prescale == '0); // true on first edge after reset

  // ====================
  // prescaler and accumulator
  // ====================
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      prescale <= '0;
      counter  <= '0;
    end else begin
      prescale <= prescale + 1'b1; // wraps naturally
      if (tick) begin
        counter <= counter + count_control; // one step per wrap
      end
    end
  end

  // low bits shown on the leds
  assign ledr = counter[$bits(led_t)-1:0];

endmodule

/* source/fabric_pkg.sv */
// shared widths and pulse lengths; table order must follow the channel indices below
package fabric_pkg;

  // ====================
  // reset request channels
  // ====================
  localparam int NUM_RESET_REQ = 3;

  localparam int RST_COLD  = 0; // cold reset request bit
  localparam int RST_WARM  = 1; // warm reset request bit
  localparam int RST_DEBUG = 2; // debug reset request bit

  typedef logic [NUM_RESET_REQ-1:0] reset_req_t; // one bit per channel

  // 6 bits covers the longest pulse (32, loaded as 31)
  typedef logic [5:0] pulse_cnt_t;

  // pulse length in clock cycles per channel
  localparam int PULSE_EXT_TABLE [NUM_RESET_REQ] = '{6, 2, 32};

  // ====================
  // counter and displays
  // ====================
  typedef logic [31:0] count_t; // accumulator and host step
  typedef logic [9:0]  led_t;   // red leds
  typedef logic [6:0]  seg_t;   // one seven segment digit

  // pulse stretcher FSM
  typedef enum logic {
    STRETCH_IDLE, // waiting for a rising edge
    STRETCH_BUSY  // pulse running, edges ignored
  } stretch_state_t;

endpackage

/* source/fabric_top.sv */
// fabric only; the processor that drives count_control, hex_control and reset_req is external
`timescale 1ns/1ns

module fabric_top import fabric_pkg::*; #(
  parameter int DIV_WIDTH = 24 // prescaler width, 24 gives a slow visible count
) (
  input  logic       CLOCK_50,
  input  logic       arst_n,
  input  count_t     count_control, // counter step
  input  count_t     hex_control,   // four display bytes
  input  reset_req_t reset_req,     // cold, warm, debug requests
  output led_t       ledr,
  output seg_t       hex0,
  output seg_t       hex1,
  output seg_t       hex2,
  output seg_t       hex3,
  output logic       cold_reset_n,
  output logic       warm_reset_n,
  output logic       debug_reset_n
);

  reset_req_t req_sync; // synchronized request levels
  reset_req_t pulse;    // stretched pulses, active high

  // ====================
  // count accumulator
  // ====================
  count_accumulator #(
    .DIV_WIDTH (DIV_WIDTH)
  ) count_accumulator_i (
    .CLOCK_50      (CLOCK_50),
    .arst_n        (arst_n),
    .count_control (count_control),
    .ledr          (ledr)
  );

  // ====================
  // seven segment displays
  // ====================
  // bit 7 of each byte is unused (no decimal point)
  assign hex0 = hex_control[6:0];
  assign hex1 = hex_control[14:8];
  assign hex2 = hex_control[22:16];
  assign hex3 = hex_control[30:24];

  // ====================
  // reset request path
  // ====================
  reset_req_sync reset_req_sync_i (
    .CLOCK_50  (CLOCK_50),
    .arst_n    (arst_n),
    .reset_req (reset_req),
    .req_sync  (req_sync)
  );

  // one stretcher per channel, length from the table
  for (genvar k = 0; k < NUM_RESET_REQ; k++) begin : g_stretch
    reset_pulse_stretch #(
      .PULSE_EXT (PULSE_EXT_TABLE[k])
    ) reset_pulse_stretch_i (
      .CLOCK_50 (CLOCK_50),
      .arst_n   (arst_n),
      .req      (req_sync[k]),
      .pulse    (pulse[k])
    );
  end

  reset_req_outputs reset_req_outputs_i (
    .CLOCK_50      (CLOCK_50),
    .arst_n        (arst_n),
    .pulse         (pulse),
    .cold_reset_n  (cold_reset_n),
    .warm_reset_n  (warm_reset_n),
    .debug_reset_n (debug_reset_n)
  );

endmodule

/* source/reset_pulse_stretch.sv */
// rising edge to fixed pulse; PULSE_EXT must lie in 1..64 and edges during a pulse are dropped
`timescale 1ns/1ns

module reset_pulse_stretch import fabric_pkg::*; #(
  parameter int PULSE_EXT = 6 // pulse length in cycles
) (
  input  logic CLOCK_50,
  input  logic arst_n,
  input  logic req,   // synchronized request level
  output logic pulse  // high for PULSE_EXT cycles
);

  // countdown starts at length minus one, ends at zero
  localparam pulse_cnt_t LOAD_CNT = pulse_cnt_t'(PULSE_EXT - 1);

  logic           req_d;     // previous req
  logic           rise;      // low to high seen this cycle
  stretch_state_t state;
  stretch_state_t state_nxt;
  pulse_cnt_t     cnt;
  pulse_cnt_t     cnt_nxt;

  // ====================
  // edge detect
  // ====================
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      req_d <= 1'b0;
    end else begin
      req_d <= req; // tracks req even while busy
    end
  end

  assign rise = req & ~req_d;

  // ====================
  // stretch FSM
  // ====================
  always_comb begin
    state_nxt = state;
    cnt_nxt   = cnt;
    case (state)
      STRETCH_IDLE: begin
        if (rise) begin
          state_nxt = STRETCH_BUSY;
          cnt_nxt   = LOAD_CNT; // first busy cycle counts
        end
      end
      STRETCH_BUSY: begin
        // rise ignored here so the pulse never restarts
        if (cnt == '0) begin
          state_nxt = STRETCH_IDLE; // last cycle done
        end else begin
          cnt_nxt = cnt - 1'b1;
        end
      end
      default: state_nxt = STRETCH_IDLE;
    endcase
  end

  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      state <= STRETCH_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
    end
  end

  assign pulse = (state == STRETCH_BUSY); // straight from state flop

endmodule

/* source/reset_req_outputs.sv */
// outputs are active low and reset high; cold masks warm and debug for its whole pulse
`timescale 1ns/1ns

module reset_req_outputs import fabric_pkg::*; (
  input  logic       CLOCK_50,
  input  logic       arst_n,
  input  reset_req_t pulse,         // stretched pulses, active high
  output logic       cold_reset_n,
  output logic       warm_reset_n,
  output logic       debug_reset_n
);

  reset_req_t pulse_q; // registered copy
  logic       cold_act; // cold pulse running

  // ====================
  // output register
  // ====================
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      pulse_q <= '0; // all requests inactive
    end else begin
      pulse_q <= pulse;
    end
  end

  assign cold_act = pulse_q[RST_COLD];

  // cold reset supersedes the other two
  assign cold_reset_n  = ~cold_act;
  assign warm_reset_n  = ~(pulse_q[RST_WARM] & ~cold_act);  // masked by cold
  assign debug_reset_n = ~(pulse_q[RST_DEBUG] & ~cold_act); // masked by cold

  // a masked warm or debug pulse is simply lost
  // it is not replayed once cold ends

endmodule

/* source/reset_req_sync.sv */
// requests are assumed quasi static levels; no multi bit coherence across channels
`timescale 1ns/1ns

module reset_req_sync import fabric_pkg::*; (
  input  logic       CLOCK_50,
  input  logic       arst_n,
  input  reset_req_t reset_req, // from host domain
  output reset_req_t req_sync   // safe to use in CLOCK_50 domain
);

  // first stage may go metastable
  reset_req_t meta;

  // ====================
  // two flop synchronizer
  // ====================
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      meta     <= '0; // both stages clear
      req_sync <= '0;
    end else begin
      meta     <= reset_req; // stage 1
      req_sync <= meta;      // stage 2
    end
  end

  // each bit is independent
  // a channel sees its request two edges after the host raises it
  // the stretcher downstream only looks for low to high transitions

endmodule

/* tb/fabric_top_props.sv */
// bound into fabric_top; watches the internal pulse bus and the three active low outputs
`timescale 1ns/1ns

module fabric_top_props import fabric_pkg::*; (
  input logic       CLOCK_50,
  input logic       arst_n,
  input reset_req_t pulse,         // stretched pulses inside the DUT
  input logic       cold_reset_n,
  input logic       warm_reset_n,
  input logic       debug_reset_n
);

  int          run_len [NUM_RESET_REQ]; // high cycles so far per channel
  logic        len_bad;                // pulse too long or ended early
  int unsigned len_fails  = 0;
  int unsigned mask_fails = 0;
  int unsigned rst_fails  = 0;

  // ====================
  // pulse length tracking
  // ====================
  always_ff @(posedge CLOCK_50 or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < NUM_RESET_REQ; k++) begin
        run_len[k] <= 0;
      end
    end else begin
      for (int k = 0; k < NUM_RESET_REQ; k++) begin
        run_len[k] <= pulse[k] ? run_len[k] + 1 : 0; // restart after each pulse
      end
    end
  end

  always_comb begin
    len_bad = 1'b0;
    for (int k = 0; k < NUM_RESET_REQ; k++) begin
      if (pulse[k] && run_len[k] >= PULSE_EXT_TABLE[k]) begin
        len_bad = 1'b1; // still high past its length
      end
      if (!pulse[k] && run_len[k] != 0 && run_len[k] != PULSE_EXT_TABLE[k]) begin
        len_bad = 1'b1; // ended at the wrong count
      end
    end
  end

  // ====================
  // properties
  // ====================
  pulse_len_a: assert property (@(posedge CLOCK_50) disable iff (!arst_n) !len_bad)
    else begin
      $error("stretched pulse length differs from the table");
      len_fails = len_fails + 1;
    end

  cold_mask_a: assert property (@(posedge CLOCK_50) !cold_reset_n |-> (warm_reset_n && debug_reset_n))
    else begin
      $error("warm or debug request low together with cold");
      mask_fails = mask_fails + 1;
    end

  // first edge after release still sees the reset values
  rst_high_a: assert property (@(posedge CLOCK_50)
      $rose(arst_n) |-> (cold_reset_n && warm_reset_n && debug_reset_n))
    else begin
      $error("reset request outputs not high after reset release");
      rst_fails = rst_fails + 1;
    end

endmodule

bind fabric_top fabric_top_props fabric_top_props_i (
  .CLOCK_50      (CLOCK_50),
  .arst_n        (arst_n),
  .pulse         (pulse),
  .cold_reset_n  (cold_reset_n),
  .warm_reset_n  (warm_reset_n),
  .debug_reset_n (debug_reset_n)
);

/* tb/fabric_top_tb.sv */
// DUT runs with DIV_WIDTH 4 so a step lands every 16 cycles; stimulus repeats from a fixed seed
`timescale 1ns/1ns

module fabric_top_tb import fabric_pkg::*; ();

  // ====================
  // run lengths
  // ====================
  localparam int TB_DIV_WIDTH    = 4;
  localparam int PRESCALE        = 1 << TB_DIV_WIDTH; // cycles per counter step
  localparam int N_COUNT         = 400; // counter and display phase
  localparam int WIN             = 48;  // window per directed pulse, longer than 4 + 32
  localparam int N_RANDOM        = 800; // random request toggling
  localparam int N_DRAIN         = 50;  // let the last pulses run out
  localparam int N_CYCLES        = 2 + N_COUNT + 7 * WIN + N_RANDOM + N_DRAIN;
  localparam int WATCHDOG_CYCLES = N_CYCLES + 100;

  logic       CLOCK_50 = 1'b0;
  logic       arst_n;
  count_t     count_control;
  count_t     hex_control;
  reset_req_t reset_req;
  led_t       ledr;
  seg_t       hex0;
  seg_t       hex1;
  seg_t       hex2;
  seg_t       hex3;
  logic       cold_reset_n;
  logic       warm_reset_n;
  logic       debug_reset_n;

  integer seed;

  // reference model state
  int         m_presc;              // prescaler copy
  count_t     m_counter;            // accumulated steps
  reset_req_t m_s1;                 // first sync stage
  reset_req_t m_s2;                 // synchronized level
  reset_req_t m_s2_d;               // level one edge back
  reset_req_t m_outq;               // registered pulses
  int         m_rem [NUM_RESET_REQ]; // pulse cycles left

  // random hold state
  count_t      cc_hold;
  int          cc_left;
  reset_req_t  rq_hold;
  int          rq_left;
  reset_req_t  outs_n; // sampled active low outputs
  int unsigned prop_fails;

  fabric_top #(
    .DIV_WIDTH (TB_DIV_WIDTH)
  ) fabric_top_i (
    .CLOCK_50      (CLOCK_50),
    .arst_n        (arst_n),
    .count_control (count_control),
    .hex_control   (hex_control),
    .reset_req     (reset_req),
    .ledr          (ledr),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .cold_reset_n  (cold_reset_n),
    .warm_reset_n  (warm_reset_n),
    .debug_reset_n (debug_reset_n)
  );

  always #10 CLOCK_50 = ~CLOCK_50; // 20 ns period

  // ====================
  // checking helpers
  // ====================
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  function automatic string out_name(input int k);
    case (k)
      RST_COLD: return "cold_reset_n";
      RST_WARM: return "warm_reset_n";
      default:  return "debug_reset_n";
    endcase
  endfunction

  task automatic clear_model();
    m_presc   = 0;
    m_counter = '0;
    m_s1      = '0;
    m_s2      = '0;
    m_s2_d    = '0;
    m_outq    = '0;
    for (int k = 0; k < NUM_RESET_REQ; k++) begin
      m_rem[k] = 0;
    end
  endtask

  // one rising edge of the model from the inputs the DUT just sampled
  task automatic advance_model();
    reset_req_t busy;
    for (int k = 0; k < NUM_RESET_REQ; k++) begin
      busy[k] = (m_rem[k] != 0);
    end
    if (m_presc == 0) begin
      m_counter = m_counter + count_control; // step on wrap
    end
    m_presc = (m_presc + 1) % PRESCALE;
    for (int k = 0; k < NUM_RESET_REQ; k++) begin
      if (m_rem[k] != 0) begin
        m_rem[k] = m_rem[k] - 1; // new edges dropped while busy
      end else if (m_s2[k] && !m_s2_d[k]) begin
        m_rem[k] = PULSE_EXT_TABLE[k];
      end
    end
    m_outq = busy; // output stage lags the pulse by one edge
    m_s2_d = m_s2;
    m_s2   = m_s1;
    m_s1   = reset_req;
  endtask

  task automatic check_outputs();
    logic exp_cold_n;
    logic exp_warm_n;
    logic exp_debug_n;
    assert (cold_reset_n || (warm_reset_n && debug_reset_n)) else begin
      $display("warm or debug reset request is low while the cold request is low");
      abort_run();
    end
    exp_cold_n  = ~m_outq[RST_COLD];
    exp_warm_n  = ~(m_outq[RST_WARM] & ~m_outq[RST_COLD]);  // cold wins
    exp_debug_n = ~(m_outq[RST_DEBUG] & ~m_outq[RST_COLD]);
    expect_equal("ledr", 32'(led_t'(m_counter)), 32'(ledr));
    expect_equal("hex0", 32'(hex_control[6:0]), 32'(hex0));   // byte 0
    expect_equal("hex1", 32'(hex_control[14:8]), 32'(hex1));
    expect_equal("hex2", 32'(hex_control[22:16]), 32'(hex2));
    expect_equal("hex3", 32'(hex_control[30:24]), 32'(hex3)); // byte 3
    expect_equal("cold_reset_n", 32'(exp_cold_n), 32'(cold_reset_n));
    expect_equal("warm_reset_n", 32'(exp_warm_n), 32'(warm_reset_n));
    expect_equal("debug_reset_n", 32'(exp_debug_n), 32'(debug_reset_n));
  endtask

  // ====================
  // stimulus helpers
  // ====================
  task automatic next_data_inputs(output count_t cc, output count_t hc);
    if (cc_left == 0) begin
      cc_hold = $random(seed);                         // new step value
      cc_left = 1 + ($unsigned($random(seed)) % 40); // held for a random span
    end
    cc_left = cc_left - 1;
    cc      = cc_hold;
    hc      = $random(seed);
  endtask

  task automatic next_random_req(output reset_req_t rq);
    if (rq_left == 0) begin
      rq_hold = reset_req_t'($random(seed));
      rq_left = 1 + ($unsigned($random(seed)) % 12);
    end
    rq_left = rq_left - 1;
    rq      = rq_hold;
  endtask

  // model at the edge then check at 1 ns and drive at 2 ns
  task automatic run_cycle(input reset_req_t rq);
    count_t cc;
    count_t hc;
    @(posedge CLOCK_50);
    advance_model();
    #1;
    check_outputs();
    outs_n[RST_COLD]  = cold_reset_n;
    outs_n[RST_WARM]  = warm_reset_n;
    outs_n[RST_DEBUG] = debug_reset_n;
    next_data_inputs(cc, hc);
    #1;
    count_control = cc;
    hex_control   = hc;
    reset_req     = rq;
  endtask

  // request driven at step 0 shows low at step 4 for the table length
  task automatic check_single_pulse(input int k, input bit retrigger);
    reset_req_t rq;
    int         first_low;
    int         span_low;
    int         low_total;
    first_low = -1;
    span_low  = 0;
    low_total = 0;
    for (int n = 0; n < WIN; n++) begin
      rq = '0;
      if (retrigger) begin
        rq[k] = (n < 2) || (n >= 4 && n < 6); // second edge lands mid pulse
      end else begin
        rq[k] = (n < 3);
      end
      run_cycle(rq);
      if (!outs_n[k]) begin
        low_total = low_total + 1;
        if (first_low < 0) begin
          first_low = n;
        end
        if (n >= 4 && n < 4 + PULSE_EXT_TABLE[k]) begin
          span_low = span_low + 1;
        end
      end
    end
    expect_equal({out_name(k), " first low step"}, 32'd4, 32'(first_low));
    expect_equal({out_name(k), " low cycles"}, 32'(PULSE_EXT_TABLE[k]), 32'(low_total));
    expect_equal({out_name(k), " contiguous low"}, 32'(PULSE_EXT_TABLE[k]), 32'(span_low));
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    seed          = 32'h906a6a13;
    arst_n        = 1'b0;
    count_control = '0;
    hex_control   = '0;
    reset_req     = '0;
    cc_left       = 0;
    rq_left       = 0;
    outs_n        = '1;
    clear_model();
    repeat (2) @(posedge CLOCK_50); // reset held two cycles
    #2;
    arst_n        = 1'b1;
    count_control = $random(seed); // first tick adds a nonzero step
    hex_control   = $random(seed);
    cc_hold       = count_control;
    cc_left       = 8;
    #1;
    // state right after reset
    expect_equal("ledr", 32'd0, 32'(ledr));
    expect_equal("cold_reset_n", 32'd1, 32'(cold_reset_n));
    expect_equal("warm_reset_n", 32'd1, 32'(warm_reset_n));
    expect_equal("debug_reset_n", 32'd1, 32'(debug_reset_n));

    // counter and displays without requests
    repeat (N_COUNT) run_cycle('0);

    // isolated pulses then second edges during a running pulse
    for (int k = 0; k < NUM_RESET_REQ; k++) begin
      check_single_pulse(k, 1'b0);
    end
    check_single_pulse(RST_COLD, 1'b1);
    check_single_pulse(RST_DEBUG, 1'b1);

    // cold overlapping warm and debug
    for (int n = 0; n < 2 * WIN; n++) begin
      reset_req_t rq;
      rq            = '0;
      rq[RST_COLD]  = (n < 3) || (n >= 58 && n < 60);  // cold inside a debug pulse
      rq[RST_WARM]  = (n >= 1 && n < 4);
      rq[RST_DEBUG] = (n >= 3 && n < 6) || (n >= 48 && n < 50);
      run_cycle(rq);
    end

    // random toggling against the model
    for (int n = 0; n < N_RANDOM; n++) begin
      reset_req_t rq;
      next_random_req(rq);
      run_cycle(rq);
    end
    repeat (N_DRAIN) run_cycle('0);

    prop_fails = fabric_top_i.fabric_top_props_i.len_fails
               + fabric_top_i.fabric_top_props_i.mask_fails
               + fabric_top_i.fabric_top_props_i.rst_fails;
    if (prop_fails != 0) begin
      $display("%0d bound property failures were reported", prop_fails);
      $display("SOME TESTS FAILED");
      $fatal(1, "property failures");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

  // hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule
